//--- rtl/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // same word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // M extension, multiply half only
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    typedef enum logic [1:0] {
        MUL, MULH, MULHSU, MULHU
    } mul_op_t;

endpackage : rv32i_pkg

//--- rtl/ooo_pkg.sv
package ooo_pkg;

    // physical register file has 64 entries
    localparam int PHYS_W = 6;

    // rob depth 64
    localparam int ROB_W = 6;

    typedef logic [PHYS_W-1:0] phys_tag_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;

    // multiplier pipeline depth, issue to output
    localparam int MUL_STAGES = 3;

endpackage : ooo_pkg

//--- rtl/fu_issue.sv
`timescale 1ns/1ps

module fu_issue (
    input  logic                clk,
    input  logic                rst,

    input  logic                issue_valid_i,
    output logic                issue_ready_o,
    input  rv32i_pkg::word_t    issue_inst_i,
    input  rv32i_pkg::word_t    issue_rs1_v_i,
    input  rv32i_pkg::word_t    issue_rs2_v_i,

    output logic                alu_valid_o,
    input  logic                alu_ready_i,
    output rv32i_pkg::alu_op_t  alu_op_o,
    output rv32i_pkg::word_t    alu_a_o,
    output rv32i_pkg::word_t    alu_b_o,
    output logic                alu_exc_o,

    output logic                mul_valid_o,
    input  logic                mul_ready_i,
    output rv32i_pkg::mul_op_t  mul_op_o,
    output rv32i_pkg::word_t    mul_a_o,
    output rv32i_pkg::word_t    mul_b_o
);
    import rv32i_pkg::*;

    inst_u inst;
    logic  is_mul;
    word_t imm_sext;

    // funct3 to op, shared by OP base and OP-IMM
    function automatic alu_op_t base_op(input logic [2:0] f3);
        case (f3)
            F3_ADD:  return ADD;
            F3_SLL:  return SLL;
            F3_SLT:  return SLT;
            F3_SLTU: return SLTU;
            F3_XOR:  return XOR;
            F3_SR:   return SRL;
            F3_OR:   return OR;
            default: return AND;
        endcase
    endfunction

    assign inst     = issue_inst_i;
    assign imm_sext = {{20{inst.i.imm[11]}}, inst.i.imm};

    always_comb begin
        is_mul    = 1'b0;
        alu_op_o  = ADD;
        mul_op_o  = MUL;
        alu_exc_o = 1'b0;
        alu_b_o   = issue_rs2_v_i;

        case (inst.r.opcode)
            OPC_OP: begin
                case (inst.r.funct7)
                    F7_BASE: alu_op_o = base_op(inst.r.funct3);
                    F7_ALT: begin
                        if (inst.r.funct3 == F3_ADD) alu_op_o = SUB;
                        else if (inst.r.funct3 == F3_SR) alu_op_o = SRA;
                        else alu_exc_o = 1'b1;
                    end
                    F7_MULDIV: begin
                        is_mul = 1'b1;
                        case (inst.r.funct3)
                            F3_MUL:    mul_op_o = MUL;
                            F3_MULH:   mul_op_o = MULH;
                            F3_MULHSU: mul_op_o = MULHSU;
                            F3_MULHU:  mul_op_o = MULHU;
                            default: begin  // divide not in this slice
                                is_mul    = 1'b0;
                                alu_exc_o = 1'b1;
                            end
                        endcase
                    end
                    default: alu_exc_o = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                alu_b_o  = imm_sext;
                alu_op_o = base_op(inst.i.funct3);
                // shift immediates carry funct7 in imm[11:5]
                if (inst.i.funct3 == F3_SLL && inst.i.imm[11:5] != F7_BASE) begin
                    alu_exc_o = 1'b1;
                end else if (inst.i.funct3 == F3_SR) begin
                    if (inst.i.imm[11:5] == F7_ALT) alu_op_o = SRA;
                    else if (inst.i.imm[11:5] != F7_BASE) alu_exc_o = 1'b1;
                end
            end
            default: alu_exc_o = 1'b1;
        endcase
    end

    assign alu_a_o = issue_rs1_v_i;
    assign mul_a_o = issue_rs1_v_i;
    assign mul_b_o = issue_rs2_v_i;

    assign alu_valid_o   = issue_valid_i && !is_mul;
    assign mul_valid_o   = issue_valid_i && is_mul;
    assign issue_ready_o = is_mul ? mul_ready_i : alu_ready_i;

    // a stalled instruction stays on the issue port unchanged
    issue_hold_a: assert property (@(posedge clk) disable iff (rst)
        issue_valid_i && !issue_ready_o |=> issue_valid_i
            && $stable({issue_inst_i, issue_rs1_v_i, issue_rs2_v_i}));

endmodule : fu_issue

//--- rtl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                clk,
    input  logic                rst,

    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  rv32i_pkg::alu_op_t  op_i,
    input  rv32i_pkg::word_t    a_i,
    input  rv32i_pkg::word_t    b_i,
    input  logic                exc_i,
    input  ooo_pkg::phys_tag_t  pd_i,
    input  ooo_pkg::rob_idx_t   rob_idx_i,

    output logic                out_valid_o,
    input  logic                out_ready_i,
    output rv32i_pkg::word_t    out_rd_v_o,
    output ooo_pkg::phys_tag_t  out_pd_o,
    output ooo_pkg::rob_idx_t   out_rob_idx_o,
    output logic                out_exc_o
);
    import rv32i_pkg::*;

    word_t      res;
    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ADD:     res = a_i + b_i;
            SUB:     res = a_i - b_i;
            SLL:     res = a_i << shamt;
            SLT:     res = {31'b0, $signed(a_i) < $signed(b_i)};
            SLTU:    res = {31'b0, a_i < b_i};
            XOR:     res = a_i ^ b_i;
            SRL:     res = a_i >> shamt;
            SRA:     res = $signed(a_i) >>> shamt;  // sign fill
            OR:      res = a_i | b_i;
            AND:     res = a_i & b_i;
            default: res = '0;
        endcase
        if (exc_i) res = '0;
    end

    // one entry, refilled while draining
    assign in_ready_o = !out_valid_o || out_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            out_rd_v_o    <= res;
            out_pd_o      <= pd_i;
            out_rob_idx_o <= rob_idx_i;
            out_exc_o     <= exc_i;
        end
    end

    hold_a: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o
            && $stable({out_rd_v_o, out_pd_o, out_rob_idx_o, out_exc_o}));

endmodule : alu_unit

//--- rtl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic                clk,
    input  logic                rst,

    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  rv32i_pkg::mul_op_t  op_i,
    input  rv32i_pkg::word_t    a_i,
    input  rv32i_pkg::word_t    b_i,
    input  ooo_pkg::phys_tag_t  pd_i,
    input  ooo_pkg::rob_idx_t   rob_idx_i,

    output logic                out_valid_o,
    input  logic                out_ready_i,
    output rv32i_pkg::word_t    out_rd_v_o,
    output ooo_pkg::phys_tag_t  out_pd_o,
    output ooo_pkg::rob_idx_t   out_rob_idx_o
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    logic [MUL_STAGES-1:0] vld_q;
    phys_tag_t             pd_q  [MUL_STAGES];
    rob_idx_t              rob_q [MUL_STAGES];
    logic                  advance;
    logic                  a_signed;
    logic                  b_signed;

    // stage payloads
    mul_op_t     op1_q;
    mul_op_t     op2_q;
    logic [32:0] a1_q;
    logic [32:0] b1_q;
    logic [65:0] prod2_q;
    word_t       res3_q;

    // whole pipe freezes when last stage is blocked
    assign advance    = !(vld_q[MUL_STAGES-1] && !out_ready_i);
    assign in_ready_o = advance;

    assign a_signed = (op_i == MULH) || (op_i == MULHSU);
    assign b_signed = (op_i == MULH);

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q <= {vld_q[MUL_STAGES-2:0], in_valid_i};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            a1_q  <= {a_signed & a_i[31], a_i};  // 33b extend
            b1_q  <= {b_signed & b_i[31], b_i};
            op1_q <= op_i;

            prod2_q <= $signed(a1_q) * $signed(b1_q);
            op2_q   <= op1_q;

            res3_q <= (op2_q == MUL) ? prod2_q[31:0] : prod2_q[63:32];

            pd_q[0]  <= pd_i;
            rob_q[0] <= rob_idx_i;
            for (int s = 1; s < MUL_STAGES; s++) begin
                pd_q[s]  <= pd_q[s-1];
                rob_q[s] <= rob_q[s-1];
            end
        end
    end

    assign out_valid_o   = vld_q[MUL_STAGES-1];
    assign out_rd_v_o    = res3_q;
    assign out_pd_o      = pd_q[MUL_STAGES-1];
    assign out_rob_idx_o = rob_q[MUL_STAGES-1];

    known_a: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(out_valid_o));

endmodule : mul_unit

//--- rtl/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                clk,
    input  logic                rst,

    input  logic                alu_valid_i,
    output logic                alu_ready_o,
    input  rv32i_pkg::word_t    alu_rd_v_i,
    input  ooo_pkg::phys_tag_t  alu_pd_i,
    input  ooo_pkg::rob_idx_t   alu_rob_idx_i,
    input  logic                alu_exc_i,

    input  logic                mul_valid_i,
    output logic                mul_ready_o,
    input  rv32i_pkg::word_t    mul_rd_v_i,
    input  ooo_pkg::phys_tag_t  mul_pd_i,
    input  ooo_pkg::rob_idx_t   mul_rob_idx_i,

    output logic                cdb_valid_o,
    input  logic                cdb_ready_i,
    output rv32i_pkg::word_t    cdb_rd_v_o,
    output ooo_pkg::phys_tag_t  cdb_pd_o,
    output ooo_pkg::rob_idx_t   cdb_rob_idx_o,
    output logic                cdb_exc_o
);
    logic lock_q;       // stalled transfer pending
    logic lock_mul_q;   // which unit owned it
    logic sel_mul;

    // mul wins unless an alu item is already stalled on the bus
    assign sel_mul = lock_q ? lock_mul_q : mul_valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            lock_q     <= 1'b0;
            lock_mul_q <= 1'b0;
        end else begin
            lock_q     <= cdb_valid_o && !cdb_ready_i;
            lock_mul_q <= sel_mul;
        end
    end

    assign mul_ready_o = sel_mul && cdb_ready_i;
    assign alu_ready_o = !sel_mul && cdb_ready_i;

    always_comb begin
        if (sel_mul) begin
            cdb_valid_o   = mul_valid_i;
            cdb_rd_v_o    = mul_rd_v_i;
            cdb_pd_o      = mul_pd_i;
            cdb_rob_idx_o = mul_rob_idx_i;
            cdb_exc_o     = 1'b0;  // multiplier never faults
        end else begin
            cdb_valid_o   = alu_valid_i;
            cdb_rd_v_o    = alu_rd_v_i;
            cdb_pd_o      = alu_pd_i;
            cdb_rob_idx_o = alu_rob_idx_i;
            cdb_exc_o     = alu_exc_i;
        end
    end

    // unit output registers and the grant lock together keep the bus steady
    cdb_hold_a: assert property (@(posedge clk) disable iff (rst)
        cdb_valid_o && !cdb_ready_i |=> cdb_valid_o
            && $stable({cdb_rd_v_o, cdb_pd_o, cdb_rob_idx_o, cdb_exc_o}));

endmodule : cdb_arbiter

//--- rtl/execute_top.sv
`timescale 1ns/1ps

module execute_top (
    input  logic                clk,
    input  logic                rst,

    input  logic                issue_valid_i,
    output logic                issue_ready_o,
    input  rv32i_pkg::word_t    issue_inst_i,
    input  rv32i_pkg::word_t    issue_rs1_v_i,
    input  rv32i_pkg::word_t    issue_rs2_v_i,
    input  ooo_pkg::phys_tag_t  issue_pd_i,
    input  ooo_pkg::rob_idx_t   issue_rob_idx_i,

    output logic                cdb_valid_o,
    input  logic                cdb_ready_i,
    output rv32i_pkg::word_t    cdb_rd_v_o,
    output ooo_pkg::phys_tag_t  cdb_pd_o,
    output ooo_pkg::rob_idx_t   cdb_rob_idx_o,
    output logic                cdb_exc_o
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    // issue to units
    logic      alu_valid, alu_ready, alu_exc;
    alu_op_t   alu_op;
    word_t     alu_a, alu_b;
    logic      mul_valid, mul_ready;
    mul_op_t   mul_op;
    word_t     mul_a, mul_b;

    // units to arbiter
    logic      alu_out_valid, alu_out_ready, alu_out_exc;
    word_t     alu_out_rd_v;
    phys_tag_t alu_out_pd;
    rob_idx_t  alu_out_rob_idx;
    logic      mul_out_valid, mul_out_ready;
    word_t     mul_out_rd_v;
    phys_tag_t mul_out_pd;
    rob_idx_t  mul_out_rob_idx;

    fu_issue fu_issue_i (
        .clk(clk), .rst(rst),
        .issue_valid_i(issue_valid_i), .issue_ready_o(issue_ready_o),
        .issue_inst_i(issue_inst_i),
        .issue_rs1_v_i(issue_rs1_v_i), .issue_rs2_v_i(issue_rs2_v_i),
        .alu_valid_o(alu_valid), .alu_ready_i(alu_ready), .alu_op_o(alu_op),
        .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_exc_o(alu_exc),
        .mul_valid_o(mul_valid), .mul_ready_i(mul_ready), .mul_op_o(mul_op),
        .mul_a_o(mul_a), .mul_b_o(mul_b)
    );

    // tags go straight to both units, only the selected one takes them
    alu_unit alu_unit_i (
        .clk(clk), .rst(rst),
        .in_valid_i(alu_valid), .in_ready_o(alu_ready), .op_i(alu_op),
        .a_i(alu_a), .b_i(alu_b), .exc_i(alu_exc),
        .pd_i(issue_pd_i), .rob_idx_i(issue_rob_idx_i),
        .out_valid_o(alu_out_valid), .out_ready_i(alu_out_ready),
        .out_rd_v_o(alu_out_rd_v), .out_pd_o(alu_out_pd),
        .out_rob_idx_o(alu_out_rob_idx), .out_exc_o(alu_out_exc)
    );

    mul_unit mul_unit_i (
        .clk(clk), .rst(rst),
        .in_valid_i(mul_valid), .in_ready_o(mul_ready), .op_i(mul_op),
        .a_i(mul_a), .b_i(mul_b),
        .pd_i(issue_pd_i), .rob_idx_i(issue_rob_idx_i),
        .out_valid_o(mul_out_valid), .out_ready_i(mul_out_ready),
        .out_rd_v_o(mul_out_rd_v), .out_pd_o(mul_out_pd),
        .out_rob_idx_o(mul_out_rob_idx)
    );

    cdb_arbiter cdb_arbiter_i (
        .clk(clk), .rst(rst),
        .alu_valid_i(alu_out_valid), .alu_ready_o(alu_out_ready),
        .alu_rd_v_i(alu_out_rd_v), .alu_pd_i(alu_out_pd),
        .alu_rob_idx_i(alu_out_rob_idx), .alu_exc_i(alu_out_exc),
        .mul_valid_i(mul_out_valid), .mul_ready_o(mul_out_ready),
        .mul_rd_v_i(mul_out_rd_v), .mul_pd_i(mul_out_pd),
        .mul_rob_idx_i(mul_out_rob_idx),
        .cdb_valid_o(cdb_valid_o), .cdb_ready_i(cdb_ready_i),
        .cdb_rd_v_o(cdb_rd_v_o), .cdb_pd_o(cdb_pd_o),
        .cdb_rob_idx_o(cdb_rob_idx_o), .cdb_exc_o(cdb_exc_o)
    );

endmodule : execute_top

//--- testbench/tb_execute_top.sv
`timescale 1ns/1ps

module tb_execute_top;
    import rv32i_pkg::*;
    import ooo_pkg::*;

    localparam int N_RAND = 48;
    localparam int ROBS   = 1 << ROB_W;

    typedef struct packed {
        word_t inst;
        word_t rs1;
        word_t rs2;
        word_t exp_v;
        logic  exp_exc;
    } row_t;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      issue_valid_i, issue_ready_o, cdb_valid_o, cdb_ready_i, cdb_exc_o;
    word_t     issue_inst_i, issue_rs1_v_i, issue_rs2_v_i, cdb_rd_v_o;
    phys_tag_t issue_pd_i, cdb_pd_o;
    rob_idx_t  issue_rob_idx_i, cdb_rob_idx_o;

    row_t      rows[$];
    string     row_name[$];
    string     names[ROBS];
    word_t     exp_val[ROBS];
    phys_tag_t exp_pd[ROBS];
    bit        exp_exc[ROBS];
    bit        pending[ROBS];
    integer    seed = 38038;
    int        err_val, err_proto, done_cnt, issued, total, hold_cnt;
    rob_idx_t  mon_idx;
    bit        stall_q;
    word_t     held_v;
    phys_tag_t held_pd;
    logic      held_exc;

    execute_top execute_top_i (.*);

    always #4 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            err_val++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input phys_tag_t exp, input phys_tag_t act);
        if (exp !== act) begin
            err_val++;
            $display("ERROR %s: expected tag %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (exp !== act) begin
            err_val++;
            $display("ERROR %s: expected flag %b, actual %b", name, exp, act);
        end
    endtask

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd3, OPC_OP_IMM};
    endfunction

    // add, xor or low product, straight from the ISA rules
    function automatic word_t rv_result(input int kind, input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (kind)
            0:       return a + b;
            1:       return a ^ b;
            default: return prod[31:0];
        endcase
    endfunction

    task automatic add_row(input string name, input word_t inst, input word_t a,
                           input word_t b, input word_t exp_v, input bit exc);
        row_t row;
        row.inst    = inst;
        row.rs1     = a;
        row.rs2     = b;
        row.exp_v   = exp_v;
        row.exp_exc = exc;
        rows.push_back(row);
        row_name.push_back(name);
    endtask

    task automatic build_table();
        add_row("add",    enc_r(F7_BASE, F3_ADD, OPC_OP),  32'h7fffffff, 32'h1, 32'h80000000, 0);
        add_row("sub",    enc_r(F7_ALT, F3_ADD, OPC_OP),   32'h5, 32'h7, 32'hfffffffe, 0);
        add_row("sll",    enc_r(F7_BASE, F3_SLL, OPC_OP),  32'h1, 32'h23, 32'h8, 0);
        add_row("slt",    enc_r(F7_BASE, F3_SLT, OPC_OP),  32'h80000000, 32'h1, 32'h1, 0);
        add_row("sltu",   enc_r(F7_BASE, F3_SLTU, OPC_OP), 32'h80000000, 32'h1, 32'h0, 0);
        add_row("xor",    enc_r(F7_BASE, F3_XOR, OPC_OP),  32'hff00ff00, 32'h0ff00ff0,
                32'hf0f0f0f0, 0);
        add_row("srl",    enc_r(F7_BASE, F3_SR, OPC_OP),   32'h80000000, 32'h4, 32'h08000000, 0);
        add_row("sra",    enc_r(F7_ALT, F3_SR, OPC_OP),    32'h80000000, 32'h4, 32'hf8000000, 0);
        add_row("or",     enc_r(F7_BASE, F3_OR, OPC_OP),   32'h12340000, 32'h5678,
                32'h12345678, 0);
        add_row("and",    enc_r(F7_BASE, F3_AND, OPC_OP),  32'hf0f0f0f0, 32'h3c3c3c3c,
                32'h30303030, 0);
        // rs2 must be ignored for immediates
        add_row("addi",   enc_i(12'hfff, F3_ADD),  32'ha, 32'hdeadbeef, 32'h9, 0);
        add_row("slli",   enc_i(12'h01f, F3_SLL),  32'h1, 32'hdeadbeef, 32'h80000000, 0);
        add_row("slti",   enc_i(12'h000, F3_SLT),  32'hffffffff, 32'hdeadbeef, 32'h1, 0);
        add_row("sltiu",  enc_i(12'hfff, F3_SLTU), 32'h1, 32'hdeadbeef, 32'h1, 0);
        add_row("xori",   enc_i(12'hfff, F3_XOR),  32'h0000ffff, 32'hdeadbeef, 32'hffff0000, 0);
        add_row("srli",   enc_i(12'h008, F3_SR),   32'h80000000, 32'hdeadbeef, 32'h00800000, 0);
        add_row("srai",   enc_i(12'h408, F3_SR),   32'h80000000, 32'hdeadbeef, 32'hff800000, 0);
        add_row("ori",    enc_i(12'h0ff, F3_OR),   32'h100, 32'hdeadbeef, 32'h1ff, 0);
        add_row("andi",   enc_i(12'h800, F3_AND),  32'h12345678, 32'hdeadbeef, 32'h12345000, 0);
        add_row("mul",    enc_r(F7_MULDIV, F3_MUL, OPC_OP),    32'h80000000, 32'hffffffff,
                32'h80000000, 0);
        add_row("mulh",   enc_r(F7_MULDIV, F3_MULH, OPC_OP),   32'h80000000, 32'h80000000,
                32'h40000000, 0);
        add_row("mulh_m1", enc_r(F7_MULDIV, F3_MULH, OPC_OP),  32'hffffffff, 32'hffffffff,
                32'h0, 0);
        add_row("mulhsu", enc_r(F7_MULDIV, F3_MULHSU, OPC_OP), 32'hffffffff, 32'hffffffff,
                32'hffffffff, 0);
        add_row("mulhu",  enc_r(F7_MULDIV, F3_MULHU, OPC_OP),  32'hffffffff, 32'hffffffff,
                32'hfffffffe, 0);
        add_row("mul_small", enc_r(F7_MULDIV, F3_MUL, OPC_OP), 32'h7, 32'h6, 32'h2a, 0);
        add_row("mulhsu_neg", enc_r(F7_MULDIV, F3_MULHSU, OPC_OP), 32'h80000000, 32'h2,
                32'hffffffff, 0);
        add_row("bad_opcode", enc_r(F7_BASE, F3_ADD, 7'b0000011), 32'h1, 32'h2, 32'h0, 1);
        add_row("bad_f7",     enc_r(7'h7f, F3_ADD, OPC_OP), 32'h1, 32'h2, 32'h0, 1);
        add_row("bad_alt_xor", enc_r(F7_ALT, F3_XOR, OPC_OP), 32'h1, 32'h2, 32'h0, 1);
        add_row("div",        enc_r(F7_MULDIV, 3'b100, OPC_OP), 32'h8, 32'h2, 32'h0, 1);
        add_row("bad_slli",   enc_i(12'h401, F3_SLL), 32'h1, 32'h0, 32'h0, 1);
        add_row("bad_srli",   enc_i(12'h021, F3_SR),  32'h1, 32'h0, 32'h0, 1);
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic issue_one(input string name, input word_t inst, input word_t a,
                             input word_t b, input word_t exp_v, input bit exc);
        rob_idx_t idx;
        idx = rob_idx_t'(issued % ROBS);
        while (pending[idx]) begin  // rob slot still in flight
            issue_valid_i = 1'b0;
            @(negedge clk);
        end
        issue_inst_i    = inst;
        issue_rs1_v_i   = a;
        issue_rs2_v_i   = b;
        issue_rob_idx_i = idx;
        issue_pd_i      = phys_tag_t'(~idx);
        issue_valid_i   = 1'b1;
        names[idx]   = name;
        exp_val[idx] = exp_v;
        exp_exc[idx] = exc;
        exp_pd[idx]  = phys_tag_t'(~idx);
        pending[idx] = 1'b1;
        @(posedge clk);
        while (!issue_ready_o) @(posedge clk);
        issued++;
        @(negedge clk);
        issue_valid_i = 1'b0;
    endtask

    // random back-pressure with occasional long stalls
    always @(negedge clk) begin
        if (!rst) begin
            if (hold_cnt != 0) begin
                cdb_ready_i = 1'b0;
                hold_cnt--;
            end else if ({$random(seed)} % 32 == 0) begin
                cdb_ready_i = 1'b0;
                hold_cnt = 8;
            end else begin
                cdb_ready_i = ({$random(seed)} % 4) != 0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (stall_q) begin
                check_flag("cdb hold valid", 1'b1, cdb_valid_o);
                check_word("cdb hold value", held_v, cdb_rd_v_o);
                check_tag("cdb hold tag", held_pd, cdb_pd_o);
                check_flag("cdb hold exc", held_exc, cdb_exc_o);
            end
            if (cdb_valid_o && cdb_ready_i) begin
                mon_idx = cdb_rob_idx_o;
                if (!pending[mon_idx]) begin
                    err_proto++;
                    $display("result for ROB index %0d arrived with nothing pending", mon_idx);
                end else begin
                    check_word(names[mon_idx], exp_val[mon_idx], cdb_rd_v_o);
                    check_tag(names[mon_idx], exp_pd[mon_idx], cdb_pd_o);
                    check_flag(names[mon_idx], exp_exc[mon_idx], cdb_exc_o);
                    pending[mon_idx] = 1'b0;
                    done_cnt++;
                end
            end
            stall_q  = cdb_valid_o && !cdb_ready_i;
            held_v   = cdb_rd_v_o;
            held_pd  = cdb_pd_o;
            held_exc = cdb_exc_o;
        end
    end

    initial begin
        @(negedge rst);
        #((row_name.size() + N_RAND) * (MUL_STAGES + 16) * 8);
        $display("watchdog expired, results never arrived (%0d of %0d done)", done_cnt, total);
        $display("tests failed");
        $finish;
    end

    initial begin
        int    kind;
        word_t a;
        word_t b;
        issue_valid_i   = 1'b0;
        issue_inst_i    = '0;
        issue_rs1_v_i   = '0;
        issue_rs2_v_i   = '0;
        issue_pd_i      = '0;
        issue_rob_idx_i = '0;
        cdb_ready_i     = 1'b1;
        build_table();
        total = row_name.size() + N_RAND;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_flag("ready after reset", 1'b1, issue_ready_o);
        check_flag("cdb idle after reset", 1'b0, cdb_valid_o);

        foreach (rows[r]) begin
            issue_one(row_name[r], rows[r].inst, rows[r].rs1, rows[r].rs2,
                      rows[r].exp_v, rows[r].exp_exc);
        end
        for (int k = 0; k < N_RAND; k++) begin
            kind = {$random(seed)} % 3;
            a = $random(seed);
            b = $random(seed);
            issue_one($sformatf("rand%0d", k),
                      enc_r(kind == 2 ? F7_MULDIV : F7_BASE,
                            kind == 1 ? F3_XOR : F3_ADD, OPC_OP),
                      a, b, rv_result(kind, a, b), 1'b0);
        end

        while (done_cnt < total) @(negedge clk);
        repeat (16) @(negedge clk);  // catch late duplicates
        $display("value errors: %0d  protocol errors: %0d  completed: %0d of %0d",
                 err_val, err_proto, done_cnt, total);
        if (err_val == 0 && err_proto == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : tb_execute_top

//--- execute.f
rtl/rv32i_pkg.sv
rtl/ooo_pkg.sv
rtl/fu_issue.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/cdb_arbiter.sv
rtl/execute_top.sv
testbench/tb_execute_top.sv

//--- Bender.yml
package:
  name: execute

sources:
  - rtl/rv32i_pkg.sv
  - rtl/ooo_pkg.sv
  - rtl/fu_issue.sv
  - rtl/alu_unit.sv
  - rtl/mul_unit.sv
  - rtl/cdb_arbiter.sv
  - rtl/execute_top.sv
  - target: test
    files:
      - testbench/tb_execute_top.sv
